// ==== verilog/mfp_ahb_lite_cfg.svh ====
`ifndef MFP_AHB_LITE_CFG_SVH
`define MFP_AHB_LITE_CFG_SVH

// address match values

// boot RAM at 0xbfc00000, physical 0x1fc00000, matched on HADDR[28:22]
`define MFP_RAM_RESET_ADDR_MATCH 7'h7f

// main RAM at 0x80000000, physical 0x00000000, matched on HADDR[28]
`define MFP_RAM_ADDR_MATCH 1'b0

// GPIO at 0xbf800000, physical 0x1f800000, matched on HADDR[28:22]
`define MFP_GPIO_ADDR_MATCH 7'h7e

// memory sizes as byte-address widths

// 1 KB boot RAM
`define MFP_RAM_RESET_ADDR_WIDTH 10

// 4 KB main RAM
`define MFP_RAM_ADDR_WIDTH 12

`endif

// ==== verilog/mfp_ahb_pkg.sv ====
package mfp_ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // sizes a 32-bit data bus can carry
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // address phase, driven by the master
    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        logic        hwrite;
        hsize_t      hsize;
    } ahb_req_t;

    // data phase result, hresp high means ERROR
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_resp_t;

    // one-hot slave select
    typedef logic [2:0] hsel_t;

    localparam int HSEL_RESET_RAM = 0;
    localparam int HSEL_RAM       = 1;
    localparam int HSEL_GPIO      = 2;

    // GPIO word offsets
    typedef enum logic [1:0] {
        RED      = 2'd0,
        GREEN    = 2'd1,
        SWITCHES = 2'd2,
        BUTTONS  = 2'd3
    } gpio_reg_e;

endpackage

// ==== verilog/mfp_ahb_lite_decoder.sv ====
`timescale 1ns/1ns

`include "mfp_ahb_lite_cfg.svh"

module mfp_ahb_lite_decoder (
    input  mfp_ahb_pkg::ahb_req_t req,
    output mfp_ahb_pkg::hsel_t    hsel
);
    import mfp_ahb_pkg::*;

    logic  active;
    hsel_t match;

    assign active = req.htrans inside {NONSEQ, SEQ};

    // boot RAM, top of the physical map
    assign match[HSEL_RESET_RAM] = (req.haddr[28:22] == `MFP_RAM_RESET_ADDR_MATCH);

    // main RAM, whole lower half
    assign match[HSEL_RAM] = (req.haddr[28] == `MFP_RAM_ADDR_MATCH);

    // GPIO, just below the boot RAM
    assign match[HSEL_GPIO] = (req.haddr[28:22] == `MFP_GPIO_ADDR_MATCH);

    // idle and busy cycles select nobody
    assign hsel = active ? match : '0;

    // the three match values must not overlap
    always_comb begin
        assert ($onehot0(match))
            else $error("decoder: address %h claimed by more than one slave", req.haddr);
    end

endmodule

// ==== verilog/mfp_ahb_lite_mem_slave.sv ====
`timescale 1ns/1ns

module mfp_ahb_lite_mem_slave #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                   HCLK,
    input  logic                   reset,
    input  logic                   hsel,
    input  mfp_ahb_pkg::ahb_req_t  req,
    input  logic                   hready,
    input  logic [31:0]            hwdata,
    output mfp_ahb_pkg::ahb_resp_t resp
);
    import mfp_ahb_pkg::*;

    localparam int WORDS = 2 ** (ADDR_WIDTH - 2);

    logic [31:0] mem [WORDS];

    logic                  accept;
    logic                  write_q;
    logic                  wr_active;
    logic [ADDR_WIDTH-1:0] addr_q;
    hsize_t                size_q;
    logic [3:0]            be;
    logic [ADDR_WIDTH-3:0] rd_index;
    logic [ADDR_WIDTH-3:0] wr_index;
    logic [31:0]           rd_word;
    logic [31:0]           rdata_q;

    assign accept    = hsel && hready && (req.htrans inside {NONSEQ, SEQ});
    assign wr_active = write_q && hready;
    assign rd_index  = req.haddr[ADDR_WIDTH-1:2];
    assign wr_index  = addr_q[ADDR_WIDTH-1:2];

    // lanes touched by the transfer now in its data phase
    always_comb begin
        case (size_q)
            BYTE:    be = 4'b0001 << addr_q[1:0];
            HALF:    be = addr_q[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            write_q <= 1'b0;
        end else if (hready) begin
            write_q <= accept && req.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            addr_q <= req.haddr[ADDR_WIDTH-1:0];
            size_q <= req.hsize;
        end
    end

    // read of the word being written this cycle gets the new lanes
    always_comb begin
        rd_word = mem[rd_index];
        if (wr_active && wr_index == rd_index) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    rd_word[8*i +: 8] = hwdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (wr_active) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[wr_index][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
        if (accept && !req.hwrite) begin
            rdata_q <= rd_word;
        end
    end

    assign resp = '{hrdata: rdata_q, hready: 1'b1, hresp: 1'b0};

    // misaligned halfword or word access from the master
    assert property (@(posedge HCLK) disable iff (reset)
        accept |-> ((req.hsize != HALF || !req.haddr[0]) &&
                    (req.hsize != WORD || req.haddr[1:0] == 2'b00)))
        else $error("mem slave: misaligned access at %h size %0d", req.haddr, req.hsize);

endmodule

// ==== verilog/mfp_ahb_gpio_slave.sv ====
`timescale 1ns/1ns

module mfp_ahb_gpio_slave (
    input  logic                   HCLK,
    input  logic                   reset,
    input  logic                   hsel,
    input  mfp_ahb_pkg::ahb_req_t  req,
    input  logic                   hready,
    input  logic [31:0]            hwdata,
    input  logic [17:0]            io_switches,
    input  logic [4:0]             io_buttons,
    output mfp_ahb_pkg::ahb_resp_t resp,
    output logic [17:0]            io_red_leds,
    output logic [8:0]             io_green_leds
);
    import mfp_ahb_pkg::*;

    logic        accept;
    logic        write_q;
    gpio_reg_e   reg_q;
    logic [17:0] red_q;
    logic [8:0]  green_q;
    logic [31:0] rdata;

    assign accept = hsel && hready && (req.htrans inside {NONSEQ, SEQ});

    always_ff @(posedge HCLK) begin
        if (reset) begin
            write_q <= 1'b0;
        end else if (hready) begin
            write_q <= accept && req.hwrite;
        end
    end

    // word offset, aliases across the whole GPIO window
    always_ff @(posedge HCLK) begin
        if (accept) begin
            reg_q <= gpio_reg_e'(req.haddr[3:2]);
        end
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            red_q   <= '0;
            green_q <= '0;
        end else if (write_q && hready) begin
            case (reg_q)
                RED:     red_q   <= hwdata[17:0];
                GREEN:   green_q <= hwdata[8:0];
                // inputs are read-only
                default: ;
            endcase
        end
    end

    // data phase read, live input values
    always_comb begin
        case (reg_q)
            RED:      rdata = {14'b0, red_q};
            GREEN:    rdata = {23'b0, green_q};
            SWITCHES: rdata = {14'b0, io_switches};
            default:  rdata = {27'b0, io_buttons};
        endcase
    end

    assign resp = '{hrdata: rdata, hready: 1'b1, hresp: 1'b0};

    assign io_red_leds   = red_q;
    assign io_green_leds = green_q;

endmodule

// ==== verilog/mfp_ahb_lite_response_mux.sv ====
`timescale 1ns/1ns

module mfp_ahb_lite_response_mux (
    input  logic                   HCLK,
    input  logic                   reset,
    input  mfp_ahb_pkg::hsel_t     hsel,
    input  mfp_ahb_pkg::ahb_req_t  req,
    input  mfp_ahb_pkg::ahb_resp_t resp_reset_ram,
    input  mfp_ahb_pkg::ahb_resp_t resp_ram,
    input  mfp_ahb_pkg::ahb_resp_t resp_gpio,
    output mfp_ahb_pkg::ahb_resp_t resp
);
    import mfp_ahb_pkg::*;

    logic  active;
    hsel_t sel_q;
    logic  err_first_q;
    logic  err_second_q;

    assign active = req.htrans inside {NONSEQ, SEQ};

    // nothing changes while the first error cycle stalls the bus
    always_ff @(posedge HCLK) begin
        if (reset) begin
            sel_q        <= '0;
            err_first_q  <= 1'b0;
            err_second_q <= 1'b0;
        end else begin
            err_second_q <= err_first_q;
            if (resp.hready) begin
                sel_q       <= hsel;
                err_first_q <= active && (hsel == '0);
            end else begin
                err_first_q <= 1'b0;
            end
        end
    end

    always_comb begin
        resp = '{hrdata: 32'h0, hready: 1'b1, hresp: 1'b0};
        if (err_first_q) begin
            resp.hready = 1'b0;
            resp.hresp  = 1'b1;
        end else if (err_second_q) begin
            resp.hresp = 1'b1;
        end else if (sel_q[HSEL_RESET_RAM]) begin
            resp = resp_reset_ram;
        end else if (sel_q[HSEL_RAM]) begin
            resp = resp_ram;
        end else if (sel_q[HSEL_GPIO]) begin
            resp = resp_gpio;
        end
    end

    // unclaimed transfer gets the two-cycle ERROR response
    assert property (@(posedge HCLK) disable iff (reset)
        (resp.hready && active && hsel == '0)
            |=> (resp.hresp && !resp.hready) ##1 (resp.hresp && resp.hready))
        else $error("response mux: ERROR response not completed");

endmodule

// ==== verilog/mfp_ahb_lite_matrix.sv ====
`timescale 1ns/1ns

`include "mfp_ahb_lite_cfg.svh"

module mfp_ahb_lite_matrix (
    input  logic                   HCLK,
    input  logic                   reset,
    input  mfp_ahb_pkg::ahb_req_t  req,
    input  logic [31:0]            hwdata,
    input  logic [17:0]            io_switches,
    input  logic [4:0]             io_buttons,
    output mfp_ahb_pkg::ahb_resp_t resp,
    output logic [17:0]            io_red_leds,
    output logic [8:0]             io_green_leds,
    output logic                   uart_tx
);
    import mfp_ahb_pkg::*;

    hsel_t     hsel;
    ahb_resp_t resp_reset_ram;
    ahb_resp_t resp_ram;
    ahb_resp_t resp_gpio;

    // no UART on this board
    assign uart_tx = 1'b0;

    mfp_ahb_lite_decoder decoder (
        .req  (req),
        .hsel (hsel)
    );

    mfp_ahb_lite_mem_slave #(
        .ADDR_WIDTH (`MFP_RAM_RESET_ADDR_WIDTH)
    ) reset_ram (
        .HCLK   (HCLK),
        .reset  (reset),
        .hsel   (hsel[HSEL_RESET_RAM]),
        .req    (req),
        .hready (resp.hready),
        .hwdata (hwdata),
        .resp   (resp_reset_ram)
    );

    mfp_ahb_lite_mem_slave #(
        .ADDR_WIDTH (`MFP_RAM_ADDR_WIDTH)
    ) ram (
        .HCLK   (HCLK),
        .reset  (reset),
        .hsel   (hsel[HSEL_RAM]),
        .req    (req),
        .hready (resp.hready),
        .hwdata (hwdata),
        .resp   (resp_ram)
    );

    mfp_ahb_gpio_slave gpio (
        .HCLK          (HCLK),
        .reset         (reset),
        .hsel          (hsel[HSEL_GPIO]),
        .req           (req),
        .hready        (resp.hready),
        .hwdata        (hwdata),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .resp          (resp_gpio),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds)
    );

    // also the default slave for unmapped addresses
    mfp_ahb_lite_response_mux response_mux (
        .HCLK           (HCLK),
        .reset          (reset),
        .hsel           (hsel),
        .req            (req),
        .resp_reset_ram (resp_reset_ram),
        .resp_ram       (resp_ram),
        .resp_gpio      (resp_gpio),
        .resp           (resp)
    );

endmodule

// ==== tests/tb_mfp_ahb_lite_matrix.sv ====
`timescale 1ns/1ns

`include "mfp_ahb_lite_cfg.svh"

module tb_mfp_ahb_lite_matrix;
    import mfp_ahb_pkg::*;

    // one bus transfer, or an idle slot when active is low
    typedef struct packed {
        logic        active;
        logic        write;
        logic [31:0] addr;
        hsize_t      size;
        logic [31:0] wdata;
        logic [17:0] switches;
        logic [4:0]  buttons;
        logic [31:0] rdata;
        logic        err;
        logic [17:0] red;
        logic [8:0]  green;
    } entry_t;

    logic        HCLK;
    logic        reset;
    ahb_req_t    req;
    logic [31:0] hwdata;
    logic [17:0] io_switches;
    logic [4:0]  io_buttons;
    ahb_resp_t   resp;
    logic [17:0] io_red_leds;
    logic [8:0]  io_green_leds;
    logic        uart_tx;

    entry_t      tab [64];
    int          n_entries;
    int          cycles = 0;
    int          cycle_limit = 0;
    integer      seed;

    // what the board looks like while the next entry is added
    logic [17:0] red_now;
    logic [8:0]  green_now;
    logic [17:0] sw_now;
    logic [4:0]  btn_now;

    mfp_ahb_lite_matrix i_mfp_ahb_lite_matrix (
        .HCLK          (HCLK),
        .reset         (reset),
        .req           (req),
        .hwdata        (hwdata),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .resp          (resp),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds),
        .uart_tx       (uart_tx)
    );

    initial begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;
    end

    always @(posedge HCLK) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: bus never finished the table after %0d cycles", cycles);
            $display("Regression failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic add_entry(input logic act, input logic wr, input logic [31:0] addr,
                             input hsize_t size, input logic [31:0] wdata,
                             input logic [31:0] rdata, input logic err);
        tab[n_entries] = '{active: act, write: wr, addr: addr, size: size, wdata: wdata,
                           switches: sw_now, buttons: btn_now, rdata: rdata, err: err,
                           red: red_now, green: green_now};
        n_entries++;
    endtask

    task automatic add_write(input logic [31:0] addr, input hsize_t size,
                             input logic [31:0] data);
        add_entry(1'b1, 1'b1, addr, size, data, '0, 1'b0);
    endtask

    task automatic add_read(input logic [31:0] addr, input logic [31:0] expected);
        add_entry(1'b1, 1'b0, addr, WORD, '0, expected, 1'b0);
    endtask

    task automatic add_idle();
        add_entry(1'b0, 1'b0, '0, BYTE, '0, '0, 1'b0);
    endtask

    task automatic build_table();
        logic [31:0] w [16];
        seed = 32'h87af;
        n_entries = 0;
        red_now = '0;
        green_now = '0;
        sw_now = '0;
        btn_now = '0;
        for (int i = 0; i < 16; i++) begin
            w[i] = $random(seed);
        end
        // word traffic, some reads right behind their write
        add_write(32'h8000_0000, WORD, w[0]);
        add_read(32'h8000_0000, w[0]);
        add_write(32'h8000_0010, WORD, w[1]);
        add_idle();
        add_read(32'h8000_0010, w[1]);
        add_write(32'hbfc0_0004, WORD, w[2]);
        add_read(32'hbfc0_0004, w[2]);
        // one RAM size up lands on the same word
        add_read(32'h8000_0000 + (32'd1 << `MFP_RAM_ADDR_WIDTH), w[0]);
        add_write(32'hbfc0_0008 + (32'd1 << `MFP_RAM_RESET_ADDR_WIDTH), WORD, w[3]);
        add_read(32'hbfc0_0008, w[3]);
        // byte lanes merge into one word
        add_write(32'h8000_0020, WORD, w[4]);
        add_write(32'h8000_0021, BYTE, w[5]);
        add_write(32'h8000_0022, HALF, w[6]);
        add_read(32'h8000_0020, {w[6][31:16], w[5][15:8], w[4][7:0]});
        add_write(32'h8000_0020, HALF, w[7]);
        add_write(32'h8000_0023, BYTE, w[8]);
        add_read(32'h8000_0020, {w[8][31:24], w[6][23:16], w[7][15:0]});
        // gpio registers
        add_write(32'hbf80_0000, WORD, w[9]);
        red_now = w[9][17:0];
        add_read(32'hbf80_0000, {14'b0, w[9][17:0]});
        add_write(32'hbf80_0004, WORD, w[10]);
        green_now = w[10][8:0];
        add_read(32'hbf80_0004, {23'b0, w[10][8:0]});
        sw_now = w[11][17:0];
        btn_now = w[11][31:27];
        add_read(32'hbf80_0008, {14'b0, sw_now});
        add_read(32'hbf80_000c, {27'b0, btn_now});
        add_write(32'hbf80_0008, WORD, w[12]);
        add_write(32'hbf80_000c, WORD, w[13]);
        add_read(32'hbf80_0008, {14'b0, sw_now});
        add_read(32'hbf80_0000, {14'b0, w[9][17:0]});
        // unmapped, a write then a read
        add_entry(1'b1, 1'b1, 32'hb000_0000, WORD, w[14], '0, 1'b1);
        add_read(32'h8000_0000, w[0]);
        add_entry(1'b1, 1'b0, 32'hb040_0020, WORD, '0, '0, 1'b1);
        add_read(32'hbfc0_0004, w[2]);
        add_idle();
        add_idle();
    endtask

    task automatic check_resp(input string where, input ahb_resp_t actual,
                              input ahb_resp_t expected, input logic check_data);
        logic bad;
        bad = 1'b0;
        if (actual.hready !== expected.hready) begin
            $display("MISMATCH at %0t %s resp.hready got %b expected %b",
                     $time, where, actual.hready, expected.hready);
            bad = 1'b1;
        end
        if (actual.hresp !== expected.hresp) begin
            $display("MISMATCH at %0t %s resp.hresp got %b expected %b",
                     $time, where, actual.hresp, expected.hresp);
            bad = 1'b1;
        end
        if (check_data && actual.hrdata !== expected.hrdata) begin
            $display("MISMATCH at %0t %s resp.hrdata got %h expected %h",
                     $time, where, actual.hrdata, expected.hrdata);
            bad = 1'b1;
        end
        if (bad) begin
            $display("Regression failed");
            $fatal(1, "bus response check failed");
        end
    endtask

    task automatic check_leds(input string where, input logic [17:0] red,
                              input logic [8:0] green, input logic [17:0] exp_red,
                              input logic [8:0] exp_green);
        logic bad;
        bad = 1'b0;
        if (red !== exp_red) begin
            $display("MISMATCH at %0t %s io_red_leds got %h expected %h",
                     $time, where, red, exp_red);
            bad = 1'b1;
        end
        if (green !== exp_green) begin
            $display("MISMATCH at %0t %s io_green_leds got %h expected %h",
                     $time, where, green, exp_green);
            bad = 1'b1;
        end
        if (bad) begin
            $display("Regression failed");
            $fatal(1, "LED check failed");
        end
    endtask

    task automatic check_uart(input string where, input logic actual,
                              input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t %s uart_tx got %b expected %b",
                     $time, where, actual, expected);
            $display("Regression failed");
            $fatal(1, "UART line check failed");
        end
    endtask

    initial begin : run
        ahb_resp_t exp;
        entry_t    e;
        int        addr_idx;
        int        data_idx;
        logic      first_cycle;
        reset = 1'b1;
        req = '{haddr: 32'h0, htrans: IDLE, hwrite: 1'b0, hsize: BYTE};
        hwdata = '0;
        io_switches = '0;
        io_buttons = '0;
        build_table();
        cycle_limit = n_entries * 4 + 20;
        repeat (2) @(posedge HCLK);
        #1 reset = 1'b0;
        @(negedge HCLK);
        check_resp("after reset", resp, '{hrdata: 32'h0, hready: 1'b1, hresp: 1'b0}, 1'b1);
        check_leds("after reset", io_red_leds, io_green_leds, '0, '0);
        check_uart("after reset", uart_tx, 1'b0);

        addr_idx = 0;
        data_idx = -1;
        first_cycle = 1'b1;
        while (addr_idx < n_entries || data_idx >= 0) begin
            @(posedge HCLK);
            #1;
            if (addr_idx < n_entries && tab[addr_idx].active) begin
                e = tab[addr_idx];
                req = '{haddr: e.addr, htrans: NONSEQ, hwrite: e.write, hsize: e.size};
            end else begin
                req = '{haddr: 32'h0, htrans: IDLE, hwrite: 1'b0, hsize: BYTE};
            end
            // reads get junk on hwdata, which must land nowhere
            if (data_idx >= 0) begin
                e = tab[data_idx];
                hwdata = e.write ? e.wdata : $random(seed);
                io_switches = e.switches;
                io_buttons = e.buttons;
            end
            @(negedge HCLK);
            if (data_idx >= 0) begin
                e = tab[data_idx];
                exp.hrdata = e.rdata;
                exp.hready = !(e.err && first_cycle);
                exp.hresp = e.err;
                check_resp($sformatf("entry %0d", data_idx), resp, exp,
                           e.active && !e.write && !e.err);
                check_uart($sformatf("entry %0d", data_idx), uart_tx, 1'b0);
                if (resp.hready) begin
                    check_leds($sformatf("entry %0d", data_idx), io_red_leds,
                               io_green_leds, e.red, e.green);
                end
            end
            // the address phase moves on only when hready is high
            if (resp.hready) begin
                data_idx = (addr_idx < n_entries) ? addr_idx : -1;
                if (addr_idx < n_entries) begin
                    addr_idx++;
                end
                first_cycle = 1'b1;
            end else begin
                first_cycle = 1'b0;
            end
        end

        repeat (2) @(posedge HCLK);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/mfp_ahb_pkg.sv
verilog/mfp_ahb_lite_decoder.sv
verilog/mfp_ahb_lite_mem_slave.sv
verilog/mfp_ahb_gpio_slave.sv
verilog/mfp_ahb_lite_response_mux.sv
verilog/mfp_ahb_lite_matrix.sv
tests/tb_mfp_ahb_lite_matrix.sv

// ==== Makefile ====
# Verilator build and run of the AHB-Lite matrix testbench

VERILATOR ?= verilator
TOP       ?= tb_mfp_ahb_lite_matrix
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "test FAILED, no result"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
